//--- Makefile
SRCS := $(shell grep -v '^+' lc3b_core.f)

obj_dir/Vtb_lc3b_core: lc3b_core.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_lc3b_core -f lc3b_core.f

run: obj_dir/Vtb_lc3b_core
	./obj_dir/Vtb_lc3b_core | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- lc3b_core.f
src/lc3b_isa_pkg.sv
src/lc3b_pipe_pkg.sv
src/lc3b_pipe_reg.sv
src/lc3b_decode.sv
src/lc3b_arch_state.sv
src/lc3b_forward.sv
src/lc3b_execute.sv
src/lc3b_core.sv
sim/tb_lc3b_core.sv

//--- sim/tb_lc3b_core.sv
module tb_lc3b_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] RESET_PC = 16'h0000;
    localparam logic [31:0] LFSR_MASK = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

    logic        clk;
    logic        i_rst_n;
    logic [15:0] o_i_mem_addr;
    logic [15:0] i_i_mem_rdata;
    logic [15:0] o_d_mem_addr;
    logic [15:0] o_d_mem_wdata;
    logic        o_d_mem_read;
    logic        o_d_mem_write;
    logic [15:0] i_d_mem_rdata;

    logic [15:0] imem [0:255];
    logic [15:0] dmem [0:1023];
    logic [15:0] mem_m [0:1023];    // Reference copy of data memory
    logic [15:0] reg_m [0:7];
    logic [2:0]  cc_m;
    logic        shadow;            // Instructions that a taken branch squashes
    logic [31:0] lfsr_state;

    logic [15:0] exp_addr [0:63];
    logic [15:0] exp_data [0:63];
    int          n_exp;
    int          store_idx;
    int          prog_len;
    logic [15:0] taken_pc [0:1];
    logic [15:0] taken_tgt [0:1];
    int          n_taken;
    logic        build_done;
    logic [15:0] prev_pc;
    int          cycles_out;
    int          mismatch_errs;
    int          other_errs;

    lc3b_core #(.RESET_PC(RESET_PC)) dut (
        .clk, .i_rst_n,
        .o_i_mem_addr, .i_i_mem_rdata,
        .o_d_mem_addr, .o_d_mem_wdata, .o_d_mem_read, .o_d_mem_write, .i_d_mem_rdata
    );

    always #4 clk = ~clk;

    // Memories answer for the current address shortly after each edge
    always @(posedge clk) begin
        #1;
        if (o_d_mem_write)
            dmem[o_d_mem_addr[10:1]] = o_d_mem_wdata;
        i_i_mem_rdata <= imem[o_i_mem_addr[8:1]];
        // Inverted word unless a load asks for it
        i_d_mem_rdata <= o_d_mem_read ? dmem[o_d_mem_addr[10:1]] : ~dmem[o_d_mem_addr[10:1]];
    end

    always @(posedge clk) begin
        prev_pc <= o_i_mem_addr;
        if (i_rst_n) begin
            cycles_out <= cycles_out + 1;
            if (o_d_mem_write)
                store_idx <= store_idx + 1;
        end
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? LFSR_MASK : 32'h0);
        return b;
    endfunction

    task automatic put_instr(input logic [15:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic write_reg(input logic [2:0] dr, input logic [15:0] v);
        if (!shadow) begin
            reg_m[dr] = v;
            cc_m = v[15] ? 3'b100 : ((v == 16'h0) ? 3'b010 : 3'b001);
        end
    endtask

    task automatic add_reg(input logic [2:0] dr, input logic [2:0] sr1, input logic [2:0] sr2);
        put_instr({4'b0001, dr, sr1, 3'b000, sr2});
        write_reg(dr, reg_m[sr1] + reg_m[sr2]);
    endtask

    task automatic add_imm(input logic [2:0] dr, input logic [2:0] sr1, input logic [4:0] imm);
        put_instr({4'b0001, dr, sr1, 1'b1, imm});
        write_reg(dr, reg_m[sr1] + {{11{imm[4]}}, imm});
    endtask

    task automatic and_reg(input logic [2:0] dr, input logic [2:0] sr1, input logic [2:0] sr2);
        put_instr({4'b0101, dr, sr1, 3'b000, sr2});
        write_reg(dr, reg_m[sr1] & reg_m[sr2]);
    endtask

    task automatic and_imm(input logic [2:0] dr, input logic [2:0] sr1, input logic [4:0] imm);
        put_instr({4'b0101, dr, sr1, 1'b1, imm});
        write_reg(dr, reg_m[sr1] & {{11{imm[4]}}, imm});
    endtask

    task automatic not_reg(input logic [2:0] dr, input logic [2:0] sr);
        put_instr({4'b1001, dr, sr, 6'b111111});
        write_reg(dr, ~reg_m[sr]);
    endtask

    task automatic load_word(input logic [2:0] dr, input logic [2:0] base, input logic [5:0] off);
        logic [15:0] addr;
        addr = reg_m[base] + {{9{off[5]}}, off, 1'b0};
        put_instr({4'b0110, dr, base, off});
        write_reg(dr, mem_m[addr[10:1]]);
    endtask

    task automatic store_word(input logic [2:0] sr, input logic [2:0] base, input logic [5:0] off);
        logic [15:0] addr;
        addr = reg_m[base] + {{9{off[5]}}, off, 1'b0};
        put_instr({4'b0111, sr, base, off});
        if (!shadow) begin
            mem_m[addr[10:1]] = reg_m[sr];
            exp_addr[n_exp] = addr;
            exp_data[n_exp] = reg_m[sr];
            n_exp++;
        end
    endtask

    // Skips four words, so a wrong decision drops or adds stores
    task automatic branch_not_taken();
        put_instr({4'b0000, ~cc_m, 9'd4});
    endtask

    task automatic branch_taken();
        logic [15:0] pc_b;
        pc_b = RESET_PC + 16'(2 * prog_len);
        taken_pc[n_taken] = pc_b;
        taken_tgt[n_taken] = pc_b + 16'd10;
        n_taken++;
        put_instr({4'b0000, cc_m, 9'd4});
        shadow = 1'b1;
        store_word(1, 7, 20);   // In the memory stage when the branch resolves
        add_imm(5, 5, 1);
        not_reg(1, 1);
        add_reg(3, 3, 3);
        shadow = 1'b0;
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++)
            imem[i] = 16'h0000;             // BR with empty nzp is a no-op
        for (int i = 0; i < 1024; i++)
            dmem[i] = 16'(i * 40503) ^ 16'h5a5a;
        for (int w = 0; w < 8; w++) begin
            for (int b = 15; b >= 0; b--)
                dmem[16'h80 + w][b] = next_bit();
        end
        for (int i = 0; i < 1024; i++)
            mem_m[i] = dmem[i];
        for (int i = 0; i < 8; i++)
            reg_m[i] = 16'h0000;
        cc_m = 3'b000;
        // Base pointer 0x0100 through back-to-back dependences
        add_imm(7, 0, 8);
        repeat (5) add_reg(7, 7, 7);
        load_word(1, 7, 0);
        load_word(2, 7, 1);
        load_word(3, 7, 2);
        load_word(4, 7, 3);
        add_reg(5, 1, 2);
        store_word(5, 7, 8);
        and_reg(5, 3, 4);
        store_word(5, 7, 9);
        not_reg(5, 1);
        store_word(5, 7, 10);
        add_imm(5, 2, 5'h19);
        store_word(5, 7, 11);
        and_imm(5, 3, 5'h0d);
        store_word(5, 7, 12);
        // Producer at distance 1, 2 and 3
        add_reg(5, 1, 2);
        add_reg(6, 5, 3);
        store_word(6, 7, 13);
        add_reg(5, 1, 4);
        and_imm(6, 2, 5);
        add_reg(6, 5, 3);
        store_word(6, 7, 14);
        add_reg(5, 2, 3);
        not_reg(6, 1);
        and_imm(0, 4, 7);
        add_reg(6, 5, 4);
        store_word(6, 7, 15);
        // Load use
        load_word(1, 7, 4);
        add_reg(5, 1, 1);
        store_word(5, 7, 16);
        load_word(2, 7, 5);
        store_word(2, 7, 17);
        // Branches on ALU and load CC
        and_imm(5, 5, 0);
        branch_not_taken();
        add_imm(5, 5, 3);
        store_word(5, 7, 18);
        add_imm(5, 5, 5'h1c);
        branch_taken();
        store_word(5, 7, 19);
        load_word(3, 7, 6);
        branch_taken();
        store_word(3, 7, 21);
        load_word(4, 7, 7);
        branch_not_taken();
        store_word(4, 7, 22);
    endtask

    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_d_mem_write |-> store_idx < n_exp)
        else begin
            other_errs++;
            $display("error at %0t: store beyond the expected list", $time);
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_d_mem_write && store_idx < n_exp) |-> o_d_mem_addr == exp_addr[store_idx])
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: o_d_mem_addr expected %h got %h", $time,
                     exp_addr[$sampled(store_idx)], $sampled(o_d_mem_addr));
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_d_mem_write && store_idx < n_exp) |-> o_d_mem_wdata == exp_data[store_idx])
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: o_d_mem_wdata expected %h got %h", $time,
                     exp_data[$sampled(store_idx)], $sampled(o_d_mem_wdata));
        end

    // Target fetched five cycles after the branch
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_i_mem_addr == taken_pc[0]) |-> ##5 (o_i_mem_addr == taken_tgt[0]))
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: o_i_mem_addr expected %h got %h", $time,
                     taken_tgt[0], $sampled(o_i_mem_addr));
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_i_mem_addr == taken_pc[1]) |-> ##5 (o_i_mem_addr == taken_tgt[1]))
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: o_i_mem_addr expected %h got %h", $time,
                     taken_tgt[1], $sampled(o_i_mem_addr));
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (cycles_out == 0) |-> (o_i_mem_addr == RESET_PC && !o_d_mem_write && !o_d_mem_read))
        else begin
            other_errs++;
            $display("error at %0t: state after reset is wrong, pc %h", $time,
                     $sampled(o_i_mem_addr));
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (cycles_out >= 1 && prev_pc < taken_pc[0] + 16'd8) |-> o_i_mem_addr == prev_pc + 16'd2)
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: o_i_mem_addr expected %h got %h", $time,
                     $sampled(prev_pc) + 16'd2, $sampled(o_i_mem_addr));
        end

    initial begin
        wait (build_done);
        #((prog_len + 40) * 16);
        $display("timeout: run did not finish, %0d of %0d stores seen", store_idx, n_exp);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        i_rst_n = 1'b0;
        i_i_mem_rdata = '0;
        i_d_mem_rdata = '0;
        lfsr_state = 32'h612dfc98;
        shadow = 1'b0;
        n_exp = 0;
        store_idx = 0;
        prog_len = 0;
        n_taken = 0;
        cycles_out = 0;
        prev_pc = '0;
        mismatch_errs = 0;
        other_errs = 0;
        build_done = 1'b0;
        build_program();
        repeat (4) put_instr(16'h0000);
        build_done = 1'b1;
        repeat (3) @(posedge clk);
        #1 i_rst_n = 1'b1;
        while (!(store_idx == n_exp && o_i_mem_addr >= RESET_PC + 16'(2 * prog_len)))
            @(posedge clk);
        repeat (8) @(posedge clk);  // Catch any late stray store
        if (store_idx != n_exp) begin
            other_errs++;
            $display("error: %0d stores seen, %0d expected", store_idx, n_exp);
        end
        $display("errors: mismatch %0d, other %0d", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- src/lc3b_arch_state.sv
module lc3b_arch_state (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  lc3b_isa_pkg::lc3b_reg  i_src1,
    input  lc3b_isa_pkg::lc3b_reg  i_src2,
    input  lc3b_isa_pkg::lc3b_reg  i_dest,
    input  lc3b_isa_pkg::lc3b_word i_wdata,
    input  logic                   i_load_regfile,
    input  logic                   i_load_cc,
    input  logic                   i_is_br,
    input  lc3b_isa_pkg::lc3b_nzp  i_br_nzp,
    output lc3b_isa_pkg::lc3b_word o_src1_data,
    output lc3b_isa_pkg::lc3b_word o_src2_data,
    output logic                   o_redirect
);

    lc3b_isa_pkg::lc3b_word regs [8];
    lc3b_isa_pkg::lc3b_nzp  cc;
    lc3b_isa_pkg::lc3b_nzp  gen_cc;    // CC from the writeback value

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
            cc   <= '0;     // Zero CC, no branch taken
        end else begin
            if (i_load_regfile)
                regs[i_dest] <= i_wdata;
            if (i_load_cc)
                cc <= gen_cc;
        end
    end

    always_comb begin
        if (i_wdata[lc3b_isa_pkg::WORD_W-1])
            gen_cc = 3'b100;
        else if (i_wdata == '0)
            gen_cc = 3'b010;
        else
            gen_cc = 3'b001;
    end

    // Same-cycle writes pass straight to the readers in decode
    assign o_src1_data = (i_load_regfile && i_dest == i_src1) ? i_wdata : regs[i_src1];
    assign o_src2_data = (i_load_regfile && i_dest == i_src2) ? i_wdata : regs[i_src2];

    assign o_redirect = i_is_br && ((i_br_nzp & cc) != '0);

    assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(cc))
        else $error("arch_state: CC two-hot %b", cc);

endmodule

//--- src/lc3b_core.sv
module lc3b_core #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // Instruction memory
    output lc3b_isa_pkg::lc3b_word o_i_mem_addr,
    input  lc3b_isa_pkg::lc3b_word i_i_mem_rdata,

    // Data memory
    output lc3b_isa_pkg::lc3b_word o_d_mem_addr,
    output lc3b_isa_pkg::lc3b_word o_d_mem_wdata,
    output logic                   o_d_mem_read,
    output logic                   o_d_mem_write,
    input  lc3b_isa_pkg::lc3b_word i_d_mem_rdata
);

    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word pc_plus2;
    logic                   id_valid;       // IF/ID slot holds a real fetch
    logic                   redirect;

    lc3b_pipe_pkg::if_id_t  if_id_d, if_id_q;
    lc3b_pipe_pkg::id_ex_t  id_ex_d, id_ex_q;
    lc3b_pipe_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    lc3b_pipe_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    lc3b_pipe_pkg::ctrl_t   dec_ctrl;
    lc3b_isa_pkg::lc3b_reg  dec_src1, dec_src2, dec_dest;
    lc3b_isa_pkg::lc3b_word src1_data, src2_data;

    logic [1:0]             fwd_a_sel, fwd_b_sel;
    lc3b_isa_pkg::lc3b_word fwd_mem;
    logic                   mem_op_ok;

    // Fetch
    assign pc_plus2     = pc + 16'd2;
    assign o_i_mem_addr = pc;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc       <= RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc       <= redirect ? mem_wb_q.br_target : pc_plus2;
            id_valid <= ~redirect;  // Fetch under a taken branch is dropped
        end
    end

    assign if_id_d = '{ir: i_i_mem_rdata, pc_plus2: pc_plus2};

    lc3b_pipe_reg #(.payload_t(lc3b_pipe_pkg::if_id_t)) u_if_id (
        .clk, .i_rst_n, .i_clear(redirect), .i_d(if_id_d), .o_q(if_id_q)
    );

    // Decode
    lc3b_decode u_decode (
        .i_ir(if_id_q.ir), .i_valid(id_valid),
        .o_ctrl(dec_ctrl), .o_src1(dec_src1), .o_src2(dec_src2), .o_dest(dec_dest)
    );

    lc3b_arch_state u_arch_state (
        .clk, .i_rst_n,
        .i_src1(dec_src1), .i_src2(dec_src2),
        .i_dest(mem_wb_q.dest), .i_wdata(mem_wb_q.wb_data),
        .i_load_regfile(mem_wb_q.ctrl.load_regfile), .i_load_cc(mem_wb_q.ctrl.load_cc),
        .i_is_br(mem_wb_q.ctrl.is_br), .i_br_nzp(mem_wb_q.dest),
        .o_src1_data(src1_data), .o_src2_data(src2_data), .o_redirect(redirect)
    );

    always_comb begin
        id_ex_d.ctrl      = dec_ctrl;
        id_ex_d.src1      = dec_src1;
        id_ex_d.src2      = dec_src2;
        id_ex_d.src1_data = src1_data;
        id_ex_d.src2_data = src2_data;
        id_ex_d.dest      = dec_dest;
        id_ex_d.offset    = if_id_q.ir[lc3b_isa_pkg::OFFSET9_W-1:0];
        id_ex_d.pc_plus2  = if_id_q.pc_plus2;
    end

    lc3b_pipe_reg #(.payload_t(lc3b_pipe_pkg::id_ex_t)) u_id_ex (
        .clk, .i_rst_n, .i_clear(redirect), .i_d(id_ex_d), .o_q(id_ex_q)
    );

    // Execute
    lc3b_forward u_forward (
        .i_src1_ex(id_ex_q.src1), .i_src2_ex(id_ex_q.src2),
        .i_dest_mem(ex_mem_q.dest), .i_dest_wb(mem_wb_q.dest),
        .i_load_regfile_mem(ex_mem_q.ctrl.load_regfile),
        .i_load_regfile_wb(mem_wb_q.ctrl.load_regfile),
        .o_fwd_a_sel(fwd_a_sel), .o_fwd_b_sel(fwd_b_sel)
    );

    lc3b_execute u_execute (
        .i_stage(id_ex_q), .i_fwd_a_sel(fwd_a_sel), .i_fwd_b_sel(fwd_b_sel),
        .i_fwd_mem(fwd_mem), .i_fwd_wb(mem_wb_q.wb_data), .o_result(ex_mem_d)
    );

    lc3b_pipe_reg #(.payload_t(lc3b_pipe_pkg::ex_mem_t)) u_ex_mem (
        .clk, .i_rst_n, .i_clear(redirect), .i_d(ex_mem_d), .o_q(ex_mem_q)
    );

    // Load data is ready in the same cycle
    assign fwd_mem = ex_mem_q.ctrl.mem_read ? i_d_mem_rdata : ex_mem_q.alu_result;

    assign mem_op_ok     = ex_mem_q.ctrl.valid & ~redirect;    // Older branch squashes it
    assign o_d_mem_addr  = ex_mem_q.mem_addr;
    assign o_d_mem_wdata = ex_mem_q.store_data;
    assign o_d_mem_read  = ex_mem_q.ctrl.mem_read & mem_op_ok;
    assign o_d_mem_write = ex_mem_q.ctrl.mem_write & mem_op_ok;

    assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, dest: ex_mem_q.dest,
                        wb_data: fwd_mem, br_target: ex_mem_q.br_target};

    lc3b_pipe_reg #(.payload_t(lc3b_pipe_pkg::mem_wb_t)) u_mem_wb (
        .clk, .i_rst_n, .i_clear(redirect), .i_d(mem_wb_d), .o_q(mem_wb_q)
    );

endmodule

//--- src/lc3b_decode.sv
module lc3b_decode (
    input  lc3b_isa_pkg::lc3b_word i_ir,
    input  logic                   i_valid,
    output lc3b_pipe_pkg::ctrl_t   o_ctrl,
    output lc3b_isa_pkg::lc3b_reg  o_src1,
    output lc3b_isa_pkg::lc3b_reg  o_src2,
    output lc3b_isa_pkg::lc3b_reg  o_dest
);

    lc3b_isa_pkg::lc3b_opcode opcode;

    assign opcode = lc3b_isa_pkg::lc3b_opcode'(
        i_ir[lc3b_isa_pkg::OPCODE_MSB:lc3b_isa_pkg::OPCODE_LSB]);

    assign o_src1 = i_ir[lc3b_isa_pkg::SR1_MSB:lc3b_isa_pkg::SR1_LSB];
    assign o_dest = i_ir[lc3b_isa_pkg::DR_MSB:lc3b_isa_pkg::DR_LSB];

    // STR reads its source register from the DR field
    assign o_src2 = (opcode == lc3b_isa_pkg::op_str) ?
                    i_ir[lc3b_isa_pkg::DR_MSB:lc3b_isa_pkg::DR_LSB] :
                    i_ir[lc3b_isa_pkg::SR2_MSB:lc3b_isa_pkg::SR2_LSB];

    always_comb begin
        o_ctrl = '0;
        if (i_valid) begin
            case (opcode)
                lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
                    o_ctrl.aluop        = (opcode == lc3b_isa_pkg::op_add) ?
                                          lc3b_isa_pkg::alu_add : lc3b_isa_pkg::alu_and;
                    o_ctrl.use_imm      = i_ir[lc3b_isa_pkg::IMM_FLAG_BIT];
                    o_ctrl.load_regfile = 1'b1;
                    o_ctrl.load_cc      = 1'b1;
                    o_ctrl.valid        = 1'b1;
                end
                lc3b_isa_pkg::op_not: begin
                    o_ctrl.aluop        = lc3b_isa_pkg::alu_not;
                    o_ctrl.load_regfile = 1'b1;
                    o_ctrl.load_cc      = 1'b1;
                    o_ctrl.valid        = 1'b1;
                end
                lc3b_isa_pkg::op_ldr: begin
                    o_ctrl.aluop        = lc3b_isa_pkg::alu_pass;
                    o_ctrl.mem_read     = 1'b1;
                    o_ctrl.load_regfile = 1'b1;
                    o_ctrl.load_cc      = 1'b1;
                    o_ctrl.valid        = 1'b1;
                end
                lc3b_isa_pkg::op_str: begin
                    o_ctrl.aluop     = lc3b_isa_pkg::alu_pass;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.valid     = 1'b1;
                end
                lc3b_isa_pkg::op_br: begin
                    o_ctrl.aluop = lc3b_isa_pkg::alu_pass;
                    o_ctrl.is_br = 1'b1;
                    o_ctrl.valid = 1'b1;
                end
                default: o_ctrl = '0;   // Unknown opcode, bubble
            endcase
        end
    end

    always_comb begin
        if (o_ctrl.valid) begin
            assert (!(o_ctrl.mem_read && o_ctrl.mem_write))
                else $error("decode: both mem_read and mem_write for ir %h", i_ir);
        end
    end

endmodule

//--- src/lc3b_execute.sv
module lc3b_execute (
    input  lc3b_pipe_pkg::id_ex_t  i_stage,
    input  logic [1:0]             i_fwd_a_sel,
    input  logic [1:0]             i_fwd_b_sel,
    input  lc3b_isa_pkg::lc3b_word i_fwd_mem,
    input  lc3b_isa_pkg::lc3b_word i_fwd_wb,
    output lc3b_pipe_pkg::ex_mem_t o_result
);

    localparam int W   = lc3b_isa_pkg::WORD_W;
    localparam int I5  = lc3b_isa_pkg::IMM5_W;
    localparam int O6  = lc3b_isa_pkg::OFFSET6_W;
    localparam int O9  = lc3b_isa_pkg::OFFSET9_W;

    lc3b_isa_pkg::lc3b_word op_a;
    lc3b_isa_pkg::lc3b_word op_b;
    lc3b_isa_pkg::lc3b_word imm5_sext;
    lc3b_isa_pkg::lc3b_word off6_sext;
    lc3b_isa_pkg::lc3b_word off9_sext;
    lc3b_isa_pkg::lc3b_word alu_b;
    lc3b_isa_pkg::lc3b_word alu_out;

    function automatic lc3b_isa_pkg::lc3b_word fwd_mux(
        input logic [1:0]             sel,
        input lc3b_isa_pkg::lc3b_word reg_val,
        input lc3b_isa_pkg::lc3b_word mem_val,
        input lc3b_isa_pkg::lc3b_word wb_val
    );
        case (sel)
            lc3b_pipe_pkg::FWD_MEM: return mem_val;
            lc3b_pipe_pkg::FWD_WB:  return wb_val;
            default:                return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(i_fwd_a_sel, i_stage.src1_data, i_fwd_mem, i_fwd_wb);
    assign op_b = fwd_mux(i_fwd_b_sel, i_stage.src2_data, i_fwd_mem, i_fwd_wb);

    // Offsets overlap in the low bits of the raw field
    assign imm5_sext = {{(W-I5){i_stage.offset[I5-1]}}, i_stage.offset[I5-1:0]};
    assign off6_sext = {{(W-O6){i_stage.offset[O6-1]}}, i_stage.offset[O6-1:0]};
    assign off9_sext = {{(W-O9){i_stage.offset[O9-1]}}, i_stage.offset[O9-1:0]};

    assign alu_b = i_stage.ctrl.use_imm ? imm5_sext : op_b;

    always_comb begin
        case (i_stage.ctrl.aluop)
            lc3b_isa_pkg::alu_add: alu_out = op_a + alu_b;
            lc3b_isa_pkg::alu_and: alu_out = op_a & alu_b;
            lc3b_isa_pkg::alu_not: alu_out = ~op_a;
            default:               alu_out = op_a;
        endcase
    end

    always_comb begin
        o_result.ctrl       = i_stage.ctrl;
        o_result.dest       = i_stage.dest;
        o_result.alu_result = alu_out;
        o_result.store_data = op_b;                         // Forwarded SR of an STR
        o_result.mem_addr   = op_a + (off6_sext << 1);      // Word offset from BaseR
        o_result.br_target  = i_stage.pc_plus2 + (off9_sext << 1);
    end

endmodule

//--- src/lc3b_forward.sv
module lc3b_forward (
    input  lc3b_isa_pkg::lc3b_reg i_src1_ex,
    input  lc3b_isa_pkg::lc3b_reg i_src2_ex,
    input  lc3b_isa_pkg::lc3b_reg i_dest_mem,
    input  lc3b_isa_pkg::lc3b_reg i_dest_wb,
    input  logic                  i_load_regfile_mem,
    input  logic                  i_load_regfile_wb,
    output logic [1:0]            o_fwd_a_sel,
    output logic [1:0]            o_fwd_b_sel
);

    // Youngest producer wins, so memory stage before writeback
    function automatic logic [1:0] pick_src(
        input lc3b_isa_pkg::lc3b_reg src,
        input lc3b_isa_pkg::lc3b_reg dest_mem,
        input logic                  ld_mem,
        input lc3b_isa_pkg::lc3b_reg dest_wb,
        input logic                  ld_wb
    );
        if (ld_mem && dest_mem == src)
            return lc3b_pipe_pkg::FWD_MEM;
        if (ld_wb && dest_wb == src)
            return lc3b_pipe_pkg::FWD_WB;
        return lc3b_pipe_pkg::FWD_REG;
    endfunction

    assign o_fwd_a_sel = pick_src(i_src1_ex, i_dest_mem, i_load_regfile_mem,
                                  i_dest_wb, i_load_regfile_wb);
    assign o_fwd_b_sel = pick_src(i_src2_ex, i_dest_mem, i_load_regfile_mem,
                                  i_dest_wb, i_load_regfile_wb);

    always_comb begin
        assert (o_fwd_a_sel inside {lc3b_pipe_pkg::FWD_REG, lc3b_pipe_pkg::FWD_MEM,
                                    lc3b_pipe_pkg::FWD_WB} &&
                o_fwd_b_sel inside {lc3b_pipe_pkg::FWD_REG, lc3b_pipe_pkg::FWD_MEM,
                                    lc3b_pipe_pkg::FWD_WB})
            else $error("forward: unused select code a=%b b=%b", o_fwd_a_sel, o_fwd_b_sel);
    end

endmodule

//--- src/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] lc3b_word;
    typedef logic [2:0]        lc3b_reg;
    typedef logic [2:0]        lc3b_nzp;

    // Subset of the LC-3b opcode map handled by this core
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11    // Operand A straight through
    } lc3b_aluop;

    // Opcode field
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;

    // DR, SR for STR, or nzp for BR
    localparam int DR_MSB = 11;
    localparam int DR_LSB = 9;

    // SR1 or BaseR
    localparam int SR1_MSB = 8;
    localparam int SR1_LSB = 6;

    localparam int IMM_FLAG_BIT = 5;    // Set selects imm5 form

    localparam int SR2_MSB = 2;
    localparam int SR2_LSB = 0;

    // Offsets all start at bit 0 and overlap
    localparam int IMM5_W    = 5;
    localparam int OFFSET6_W = 6;
    localparam int OFFSET9_W = 9;

endpackage

//--- src/lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

    // Operand source selects for the execute stage
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_MEM = 2'b01;
    localparam logic [1:0] FWD_WB  = 2'b10;

    typedef struct packed {
        lc3b_isa_pkg::lc3b_aluop aluop;
        logic                    use_imm;       // ALU B from imm5
        logic                    load_regfile;
        logic                    load_cc;
        logic                    mem_read;
        logic                    mem_write;
        logic                    is_br;
        logic                    valid;
    } ctrl_t;

    typedef struct packed {
        lc3b_isa_pkg::lc3b_word ir;
        lc3b_isa_pkg::lc3b_word pc_plus2;
    } if_id_t;

    typedef struct packed {
        ctrl_t                                ctrl;
        lc3b_isa_pkg::lc3b_reg                src1;
        lc3b_isa_pkg::lc3b_reg                src2;
        lc3b_isa_pkg::lc3b_word               src1_data;
        lc3b_isa_pkg::lc3b_word               src2_data;
        lc3b_isa_pkg::lc3b_reg                dest;     // nzp for BR
        logic [lc3b_isa_pkg::OFFSET9_W-1:0]   offset;   // Raw ir[8:0]
        lc3b_isa_pkg::lc3b_word               pc_plus2;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        lc3b_isa_pkg::lc3b_reg  dest;
        lc3b_isa_pkg::lc3b_word alu_result;
        lc3b_isa_pkg::lc3b_word store_data;
        lc3b_isa_pkg::lc3b_word mem_addr;
        lc3b_isa_pkg::lc3b_word br_target;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        lc3b_isa_pkg::lc3b_reg  dest;
        lc3b_isa_pkg::lc3b_word wb_data;    // ALU result or load data
        lc3b_isa_pkg::lc3b_word br_target;
    } mem_wb_t;

endpackage

//--- src/lc3b_pipe_reg.sv
module lc3b_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_clear,
    input  payload_t i_d,
    output payload_t o_q
);

    // Loads every cycle, no stalls in this pipeline
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_q <= '0;
        else if (i_clear)
            o_q <= '0;  // Squash, valid drops with the rest
        else
            o_q <= i_d;
    end

endmodule
